/* hw/disp_params.svh */
`ifndef DISP_PARAMS_SVH
`define DISP_PARAMS_SVH

// ----------------------------
// Horizontal geometry
// ----------------------------

// Visible pixels per line
`define DISP_H_DISPLAY 640
// Pixels between end of video and hsync
`define DISP_H_FRONT 16
// Hsync pulse width in pixels
`define DISP_H_SYNC 96
// Pixels from hsync to next line
`define DISP_H_BACK 48

// ----------------------------
// Vertical geometry
// ----------------------------

// Visible lines per frame
`define DISP_V_DISPLAY 480
// Lines after last visible line
`define DISP_V_FRONT 11
// Vsync pulse width in lines
`define DISP_V_SYNC 2
// Lines from vsync to top of frame
`define DISP_V_BACK 31

// ----------------------------
// Widths and reset
// ----------------------------

// Wide enough for any single phase
`define DISP_LEN_WIDTH 11

// Cycles of forced reset after rstN goes high
`define RST_HOLD_CYCLES 16

`endif

/* hw/sysTypesPkg.sv */
`default_nettype none

package sysTypesPkg;

    // ----------------------------
    // Reset sequencer
    // ----------------------------

    // Hold while counting, run once released
    typedef enum logic {
        RstHold,
        RstRun
    } rstState_e;

endpackage

`default_nettype wire

/* hw/dispTypesPkg.sv */
`default_nettype none

`include "disp_params.svh"

package dispTypesPkg;

    // ----------------------------
    // Axis phases
    // ----------------------------

    // Same order for both axes
    // Active first so reset lands on pixel 0
    typedef enum logic [1:0] {
        PhActive,
        PhFront,
        PhSync,
        PhBack
    } dispPhase_e;

    // ----------------------------
    // Lengths
    // ----------------------------

    // Phase length, also the timer count
    typedef logic [`DISP_LEN_WIDTH-1:0] phaseLen_t;

endpackage

`default_nettype wire

/* hw/resetStretcher.sv */
`default_nettype none

`include "disp_params.svh"

module resetStretcher
    import sysTypesPkg::*;
(
    input  logic clk,
    input  logic rstN,
    output logic rst
);

    // Counter must reach the hold length itself
    localparam int holdWidth = $clog2(`RST_HOLD_CYCLES + 1);

    rstState_e             state;
    logic [holdWidth-1:0]  holdCnt;

    // ----------------------------
    // Hold sequencer
    // ----------------------------

    always_ff @(posedge clk) begin
        if (!rstN) begin
            // Any low sample restarts the hold
            state   <= RstHold;
            holdCnt <= '0;
        end else if (state == RstHold) begin
            if (holdCnt == holdWidth'(`RST_HOLD_CYCLES)) begin
                state <= RstRun;
            end else begin
                holdCnt <= holdCnt + 1'b1;
            end
        end
    end

    // Active high, straight from state
    // Falls on edge N after the first high sample
    assign rst = (state == RstHold);

endmodule

`default_nettype wire

/* hw/phaseTimer.sv */
`default_nettype none

module phaseTimer
    import dispTypesPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      step,
    input  logic      load,
    input  phaseLen_t loadLen,
    output logic      last
);

    // Remaining counts in the phase, zero on the final one
    phaseLen_t count;

    // ----------------------------
    // Down-counter
    // ----------------------------

    always_ff @(posedge clk) begin
        if (rst || load) begin
            // Reset also reloads, so the first phase starts full length
            count <= loadLen - 1'b1;
        end else if (step) begin
            count <= count - 1'b1;
        end
    end

    // Held for the whole last count
    // Vertical axis: the whole last line
    assign last = (count == '0);

endmodule

`default_nettype wire

/* hw/phaseFsm.sv */
`default_nettype none

`include "disp_params.svh"

module phaseFsm
    import dispTypesPkg::*;
#(
    parameter phaseLen_t activeLen = phaseLen_t'(`DISP_H_DISPLAY),
    parameter phaseLen_t frontLen  = phaseLen_t'(`DISP_H_FRONT),
    parameter phaseLen_t syncLen   = phaseLen_t'(`DISP_H_SYNC),
    parameter phaseLen_t backLen   = phaseLen_t'(`DISP_H_BACK)
)(
    input  logic       clk,
    input  logic       rst,
    input  logic       step,
    output dispPhase_e phase,
    output logic       load,
    output phaseLen_t  loadLen,
    output logic       phaseEnd,
    input  logic       timerLast
);

    dispPhase_e succPhase;
    dispPhase_e loadPhase;
    logic       advance;

    // Length lookup per phase
    function automatic phaseLen_t lenOf(input dispPhase_e ph);
        case (ph)
            PhActive: lenOf = activeLen;
            PhFront:  lenOf = frontLen;
            PhSync:   lenOf = syncLen;
            default:  lenOf = backLen;
        endcase
    endfunction

    // ----------------------------
    // Next phase
    // ----------------------------

    // Last count of the phase, consumed by a step
    assign advance = step && timerLast;

    always_comb begin
        case (phase)
            PhActive: succPhase = PhFront;
            PhFront:  succPhase = PhSync;
            PhSync:   succPhase = PhBack;
            default:  succPhase = PhActive;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= PhActive;
        end else if (advance) begin
            phase <= succPhase;
        end
    end

    // ----------------------------
    // Timer control
    // ----------------------------

    // Timer reloads on its own reset too, so present Active length then
    assign loadPhase = rst ? PhActive : succPhase;
    assign loadLen   = lenOf(loadPhase);
    assign load      = advance;

    // Wrap from Back to Active
    // Horizontal axis: this is the line end
    assign phaseEnd = advance && (phase == PhBack);

endmodule

`default_nettype wire

/* hw/syncOutput.sv */
`default_nettype none

module syncOutput
    import dispTypesPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  dispPhase_e hPhase,
    input  dispPhase_e vPhase,
    input  logic       hLast,
    input  logic       vLast,
    output logic       vde,
    output logic       fvde,
    output logic       fe,
    output logic       hsync,
    output logic       vsync
);

    logic hActive;
    logic vActive;
    logic pixelActive;

    // ----------------------------
    // Phase decode
    // ----------------------------

    assign hActive     = (hPhase == PhActive);
    assign vActive     = (vPhase == PhActive);
    assign pixelActive = hActive && vActive;

    // ----------------------------
    // Output registers
    // ----------------------------

    // One cycle behind the phases
    always_ff @(posedge clk) begin
        if (rst) begin
            // Idle levels, syncs high
            vde   <= 1'b0;
            fvde  <= 1'b0;
            fe    <= 1'b0;
            hsync <= 1'b1;
            vsync <= 1'b1;
        end else begin
            vde   <= pixelActive;
            fvde  <= vActive;
            // Last pixel of last active line
            fe    <= pixelActive && hLast && vLast;
            // Active-low syncs
            hsync <= (hPhase != PhSync);
            vsync <= (vPhase != PhSync);
        end
    end

endmodule

`default_nettype wire

/* hw/preProcessor.sv */
`default_nettype none

`include "disp_params.svh"

module preProcessor
    import dispTypesPkg::*;
#(
    parameter int hDisplay = `DISP_H_DISPLAY,
    parameter int hFront   = `DISP_H_FRONT,
    parameter int hSync    = `DISP_H_SYNC,
    parameter int hBack    = `DISP_H_BACK,
    parameter int vDisplay = `DISP_V_DISPLAY,
    parameter int vFront   = `DISP_V_FRONT,
    parameter int vSync    = `DISP_V_SYNC,
    parameter int vBack    = `DISP_V_BACK
)(
    input  logic clk,
    input  logic rstN,
    output logic rst,
    output logic vde,
    output logic fvde,
    output logic fe,
    output logic hsync,
    output logic vsync
);

    dispPhase_e hPhase;
    dispPhase_e vPhase;
    logic       hLoad;
    logic       vLoad;
    phaseLen_t  hLoadLen;
    phaseLen_t  vLoadLen;
    logic       hLast;
    logic       vLast;
    logic       lineEnd;

    // ----------------------------
    // Reset
    // ----------------------------

    resetStretcher rstGen (
        .clk  (clk),
        .rstN (rstN),
        .rst  (rst)
    );

    // ----------------------------
    // Horizontal, one count per clock
    // ----------------------------

    phaseFsm #(
        .activeLen (phaseLen_t'(hDisplay)),
        .frontLen  (phaseLen_t'(hFront)),
        .syncLen   (phaseLen_t'(hSync)),
        .backLen   (phaseLen_t'(hBack))
    ) hFsm (
        .clk       (clk),
        .rst       (rst),
        .step      (1'b1),
        .phase     (hPhase),
        .load      (hLoad),
        .loadLen   (hLoadLen),
        .phaseEnd  (lineEnd),
        .timerLast (hLast)
    );

    phaseTimer hTimer (
        .clk     (clk),
        .rst     (rst),
        .step    (1'b1),
        .load    (hLoad),
        .loadLen (hLoadLen),
        .last    (hLast)
    );

    // ----------------------------
    // Vertical, one count per line
    // ----------------------------

    // Frame end comes from the output stage instead
    phaseFsm #(
        .activeLen (phaseLen_t'(vDisplay)),
        .frontLen  (phaseLen_t'(vFront)),
        .syncLen   (phaseLen_t'(vSync)),
        .backLen   (phaseLen_t'(vBack))
    ) vFsm (
        .clk       (clk),
        .rst       (rst),
        .step      (lineEnd),
        .phase     (vPhase),
        .load      (vLoad),
        .loadLen   (vLoadLen),
        .phaseEnd  (),
        .timerLast (vLast)
    );

    phaseTimer vTimer (
        .clk     (clk),
        .rst     (rst),
        .step    (lineEnd),
        .load    (vLoad),
        .loadLen (vLoadLen),
        .last    (vLast)
    );

    // ----------------------------
    // Output stage
    // ----------------------------

    syncOutput outStage (
        .clk    (clk),
        .rst    (rst),
        .hPhase (hPhase),
        .vPhase (vPhase),
        .hLast  (hLast),
        .vLast  (vLast),
        .vde    (vde),
        .fvde   (fvde),
        .fe     (fe),
        .hsync  (hsync),
        .vsync  (vsync)
    );

endmodule

`default_nettype wire

/* testbench/preProcessor_properties.sv */
`default_nettype none

module preProcessorProperties (
    input logic clk,
    input logic rst,
    input logic lineEnd,
    input logic vde,
    input logic fvde,
    input logic fe,
    input logic hsync,
    input logic vsync
);

    // First edges still carry power-up values
    logic [1:0] settleCnt = 2'd0;

    // Running count of failed assertions
    int failCount = 0;

    always @(posedge clk) begin
        if (settleCnt != 2'd3) begin
            settleCnt <= settleCnt + 2'd1;
        end
    end

    // ----------------------------
    // Output relations
    // ----------------------------

    // Frame end on the last pixel of a line
    feOnPixel: assert property (@(posedge clk) disable iff (settleCnt != 2'd3)
        $past(fe) |-> ($past(vde) && !vde))
        else begin
            $error("fe not on the last vde cycle of a line");
            failCount++;
        end

    // Hsync and back porch lie in blanking
    vdeOutsideHsync: assert property (@(posedge clk) disable iff (settleCnt != 2'd3)
        vde |-> (hsync && $past(hsync)))
        else begin
            $error("vde high during hsync or right after it");
            failCount++;
        end

    // Output lags the line end by two edges
    fvdeAtLineEdge: assert property (@(posedge clk) disable iff (settleCnt != 2'd3 || rst)
        (fvde != $past(fvde)) |-> ($past(lineEnd, 2) || $past(rst, 2)))
        else begin
            $error("fvde moved inside a line");
            failCount++;
        end

    // Idle levels once reset has reached the registers
    idleInReset: assert property (@(posedge clk) disable iff (settleCnt != 2'd3)
        (rst && $past(rst)) |-> (!vde && !fvde && !fe && hsync && vsync))
        else begin
            $error("outputs active during reset");
            failCount++;
        end

endmodule

bind preProcessor preProcessorProperties props (
    .clk     (clk),
    .rst     (rst),
    .lineEnd (lineEnd),
    .vde     (vde),
    .fvde    (fvde),
    .fe      (fe),
    .hsync   (hsync),
    .vsync   (vsync)
);

`default_nettype wire

/* testbench/preProcessorTb.sv */
`default_nettype none

`include "disp_params.svh"

module preProcessorTb;

    // ----------------------------
    // Small geometry
    // ----------------------------

    localparam int hDisp    = 8;
    localparam int hFront   = 2;
    localparam int hSyncW   = 3;
    localparam int hBack    = 1;
    localparam int vDisp    = 4;
    localparam int vFront   = 1;
    localparam int vSyncW   = 2;
    localparam int vBack    = 1;
    localparam int hLine    = hDisp + hFront + hSyncW + hBack;
    localparam int frameLen = hLine * (vDisp + vFront + vSyncW + vBack);
    // Reset-load cycle plus one output register
    localparam int vdeDelay = 2;
    // Last pixel of the last active line
    localparam int firstFe  = vdeDelay + (vDisp - 1) * hLine + hDisp - 1;
    localparam int maxCases = 16;

    logic clk;
    logic rstN;
    logic rst;
    logic vde;
    logic fvde;
    logic fe;
    logic hsync;
    logic vsync;

    // Columns of the cases file
    int caseRstLow [maxCases];
    int caseFrames [maxCases];
    int caseMid [maxCases];
    int caseVdeLen [maxCases];
    int caseHsyncW [maxCases];
    int caseVsyncLines [maxCases];
    int caseFeSpacing [maxCases];
    int caseVdeDelay [maxCases];
    int numCases = 0;
    int curCase = 0;

    int     errCount = 0;
    int     checkCount = 0;
    int     seed;
    longint limitTime;
    logic   limitReady = 1'b0;

    // Monitor state
    // Cycle numbers count from the first rst-low cycle
    int   cyc = 0;
    int   releaseCyc = 0;
    int   relIdx = 0;
    int   vdeRun = 0;
    int   hsyncRun = 0;
    int   vsyncRun = 0;
    int   fvdeRun = 0;
    int   lastVdeRise = 0;
    int   lastFe = 0;
    int   linesInFrame = 0;
    int   feCount = 0;
    logic rstPrev = 1'b1;
    logic rstNPrev = 1'b0;
    logic vdePrev = 1'b0;
    logic fvdePrev = 1'b0;
    logic hsyncPrev = 1'b1;
    logic vsyncPrev = 1'b1;

    preProcessor #(
        .hDisplay (hDisp),
        .hFront   (hFront),
        .hSync    (hSyncW),
        .hBack    (hBack),
        .vDisplay (vDisp),
        .vFront   (vFront),
        .vSync    (vSyncW),
        .vBack    (vBack)
    ) uut (
        .clk   (clk),
        .rstN  (rstN),
        .rst   (rst),
        .vde   (vde),
        .fvde  (fvde),
        .fe    (fe),
        .hsync (hsync),
        .vsync (vsync)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    task automatic checkValue(input string what, input int got, input int want);
        checkCount++;
        if (got != want) begin
            errCount++;
            $display("error at %0t: %s is %0d, expected %0d", $time, what, got, want);
        end
    endtask

    task automatic readCases();
        int    fd;
        int    n;
        string line;
        fd = $fopen("testbench/timing_cases.txt", "r");
        if (fd == 0) begin
            return;
        end
        while (!$feof(fd) && numCases < maxCases) begin
            line = "";
            n = $fgets(line, fd);
            // Skip blanks and column notes
            if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%d %d %d %d %d %d %d %d", caseRstLow[numCases],
                    caseFrames[numCases], caseMid[numCases], caseVdeLen[numCases],
                    caseHsyncW[numCases], caseVsyncLines[numCases],
                    caseFeSpacing[numCases], caseVdeDelay[numCases]);
                if (n == 8) begin
                    numCases++;
                end else begin
                    errCount++;
                    $display("malformed line in the cases file: %s", line);
                end
            end
        end
        $fclose(fd);
    endtask

    // ----------------------------
    // Watchdog
    // ----------------------------

    initial begin
        wait (limitReady);
        #(limitTime);
        $display("timeout: the run did not finish within %0d time units", limitTime);
        $display("RESULT: FAIL");
        $finish;
    end

    // ----------------------------
    // Output monitor
    // ----------------------------

    // Sampled half a cycle after the registers move
    always @(negedge clk) begin
        cyc = cyc + 1;
        if (rstN && !rstNPrev) begin
            releaseCyc = cyc;
        end
        if (rst) begin
            // Registers catch up one edge after rst rises
            if (rstPrev && cyc > 2) begin
                checkValue("outputs in reset", int'({vde, fvde, fe, hsync, vsync}), 3);
            end
            relIdx = 0;
            feCount = 0;
            lastVdeRise = 0;
            lastFe = 0;
            linesInFrame = 0;
        end else begin
            if (rstPrev) begin
                relIdx = 1;
                // rstN is first sampled high on the edge after it rises
                checkValue("rst hold", cyc - releaseCyc - 1, `RST_HOLD_CYCLES);
            end else begin
                relIdx++;
            end
            // Pixel runs and line period
            if (vde && !vdePrev) begin
                if (lastVdeRise == 0) begin
                    checkValue("first vde cycle", relIdx, caseVdeDelay[curCase]);
                end else if (fvdePrev) begin
                    checkValue("line period", relIdx - lastVdeRise, hLine);
                end
                lastVdeRise = relIdx;
                linesInFrame = fvdePrev ? linesInFrame + 1 : 1;
            end
            if (vde) begin
                vdeRun = vdePrev ? vdeRun + 1 : 1;
            end else if (vdePrev) begin
                checkValue("vde run", vdeRun, caseVdeLen[curCase]);
            end
            if (!hsync) begin
                hsyncRun = hsyncPrev ? 1 : hsyncRun + 1;
            end else if (!hsyncPrev) begin
                checkValue("hsync low width", hsyncRun, caseHsyncW[curCase]);
            end
            // Vsync and fvde in whole lines
            if (!vsync) begin
                vsyncRun = vsyncPrev ? 1 : vsyncRun + 1;
            end else if (!vsyncPrev) begin
                checkValue("vsync low cycles", vsyncRun, caseVsyncLines[curCase] * hLine);
            end
            if (fvde) begin
                fvdeRun = fvdePrev ? fvdeRun + 1 : 1;
            end else if (fvdePrev) begin
                checkValue("fvde cycles", fvdeRun, vDisp * hLine);
            end
            if (fe) begin
                feCount++;
                checkValue("fe pixel in line", vde ? vdeRun : 0, hDisp);
                checkValue("fe line in frame", linesInFrame, vDisp);
                if (lastFe == 0) begin
                    checkValue("first fe cycle", relIdx, firstFe);
                end else begin
                    checkValue("fe spacing", relIdx - lastFe, caseFeSpacing[curCase]);
                end
                lastFe = relIdx;
            end
        end
        rstPrev = rst;
        rstNPrev = rstN;
        vdePrev = vde;
        fvdePrev = fvde;
        hsyncPrev = hsync;
        vsyncPrev = vsync;
    end

    // ----------------------------
    // Stimulus
    // ----------------------------

    initial begin
        int total;
        int offset;
        rstN = 1'b0;
        seed = 27442;
        readCases();
        if (numCases == 0) begin
            errCount++;
            $display("no cases were read from testbench/timing_cases.txt");
        end
        // Margin for the first hold
        total = `RST_HOLD_CYCLES;
        for (int i = 0; i < numCases; i++) begin
            total += caseFrames[i] * frameLen + caseRstLow[i] + `RST_HOLD_CYCLES;
        end
        limitTime = longint'(total) * 8 * 2;
        limitReady = 1'b1;
        for (int c = 0; c < numCases; c++) begin
            // File values against the timing rules
            checkValue("file vde run", caseVdeLen[c], hDisp);
            checkValue("file hsync width", caseHsyncW[c], hSyncW);
            checkValue("file vsync lines", caseVsyncLines[c], vSyncW);
            checkValue("file fe spacing", caseFeSpacing[c], frameLen);
            checkValue("file vde delay", caseVdeDelay[c], vdeDelay);
            @(posedge clk);
            // Somewhere inside the running frame
            if (caseMid[c] != 0) begin
                offset = 1 + int'($unsigned($random(seed)) % (frameLen - 1));
                repeat (offset) @(posedge clk);
            end
            curCase = c;
            rstN <= 1'b0;
            repeat (caseRstLow[c]) @(posedge clk);
            rstN <= 1'b1;
            @(posedge clk);
            while (relIdx == 0) begin
                @(posedge clk);
            end
            while (feCount < caseFrames[c]) begin
                @(posedge clk);
            end
        end
        $display("checks: %0d, errors: %0d, assertion failures: %0d", checkCount, errCount,
            uut.props.failCount);
        if (errCount == 0 && uut.props.failCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/timing_cases.txt */
# rstLow frames midReset vdeRun hsyncLow vsyncLines feSpacing firstVde
# lengths in clock cycles, vsync in lines, midReset 1 = reset at a random point
5 2 0 8 3 2 112 2
1 1 1 8 3 2 112 2
3 2 1 8 3 2 112 2
2 1 0 8 3 2 112 2
7 3 1 8 3 2 112 2
1 2 1 8 3 2 112 2
4 1 1 8 3 2 112 2
6 2 0 8 3 2 112 2

/* list.f */
+incdir+hw
hw/sysTypesPkg.sv
hw/dispTypesPkg.sv
hw/resetStretcher.sv
hw/phaseTimer.sv
hw/phaseFsm.sv
hw/syncOutput.sv
hw/preProcessor.sv
testbench/preProcessor_properties.sv
testbench/preProcessorTb.sv

/* Makefile */
# Verilator flow for the display timing front end

VERILATOR ?= verilator
TOP       ?= preProcessorTb
RTL_TOP   ?= preProcessor
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_TEXT ?= RESULT: PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Pass only when the pass line appears in the run output
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)
